//--- Makefile
TOP = memSubsystem_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f project.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

//--- accessArbiter.sv
`timescale 1ns/1ps
`include "memCtrl_settings.svh"

module accessArbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              fetchEn,
    input  logic              dataEn,
    input  logic              dataStore,
    input  memPkg::len_t      dataLen,
    input  logic              isLast,
    output memPkg::busOwner_e owner,
    output logic              cntStart,
    output logic              cntStep,
    output memPkg::len_t      accLen,
    output logic              ramWe,
    output logic              capture,
    output logic              clearWord,
    output logic              fetchDone,
    output logic              dataDone
);

    memPkg::arbState_e state;
    memPkg::arbState_e stateNext;
    logic              anyReq;
    logic              busy;
    logic              isData;

    assign anyReq = dataEn | fetchEn;
    assign busy   = (state != memPkg::stIdle);
    assign isData = (state == memPkg::stLoad) || (state == memPkg::stStore);

    // data side wins in idle, the grant then holds until the last byte
    always_comb begin
        stateNext = state;
        case (state)
            memPkg::stIdle: begin
                if (dataEn) begin
                    stateNext = dataStore ? memPkg::stStore : memPkg::stLoad;
                end else if (fetchEn) begin
                    stateNext = memPkg::stFetch;
                end
            end
            memPkg::stFetch,
            memPkg::stLoad,
            memPkg::stStore: begin
                if (isLast) begin
                    stateNext = memPkg::stIdle;
                end
            end
            default: begin
                stateNext = memPkg::stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::stIdle;
        end else if (rdy) begin
            state <= stateNext;
        end
    end

    always_comb begin
        case (state)
            memPkg::stFetch: owner = memPkg::ownFetch;
            memPkg::stLoad:  owner = memPkg::ownData;
            memPkg::stStore: owner = memPkg::ownData;
            default:         owner = memPkg::ownNone;
        endcase
    end

    // fetch length is fixed, data length comes from the held request
    assign accLen = (state == memPkg::stFetch) ? memPkg::len_t'(`FETCH_BYTES) : dataLen;

    // counter pulses, rdy is applied inside the counter
    assign cntStart  = !busy && anyReq;
    assign cntStep   = busy && !isLast;
    assign clearWord = !busy && anyReq;

    assign ramWe   = (state == memPkg::stStore) && rdy;
    assign capture = (state == memPkg::stLoad) || (state == memPkg::stFetch);

    // completions only in the last cycle of a ready access
    assign fetchDone = (state == memPkg::stFetch) && isLast && rdy;
    assign dataDone  = isData && isLast && rdy;

endmodule

//--- byteCounter.sv
`timescale 1ns/1ps

module byteCounter (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           start,
    input  logic           step,
    input  memPkg::len_t   len,
    input  logic           storeMode,
    output memPkg::stage_t stage,
    output logic           isLast
);

    memPkg::stage_t stopAt;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (rdy) begin
            if (start) begin
                stage <= '0;
            end else if (step) begin
                stage <= stage + memPkg::stage_t'(1);
            end
        end
    end

    // stores end on the last written byte, reads one stage later
    // since the RAM returns each byte a cycle late
    always_comb begin
        if (storeMode) begin
            stopAt = memPkg::stage_t'(len - memPkg::len_t'(1));
        end else begin
            stopAt = memPkg::stage_t'(len);
        end
    end

    assign isLast = (stage == stopAt);

endmodule

//--- byteRam.sv
`timescale 1ns/1ps
`include "memCtrl_settings.svh"

module byteRam (
    input  logic          clk,
    input  logic          we,
    input  memPkg::addr_t addr,
    input  memPkg::byte_t wbyte,
    output memPkg::byte_t rbyte
);

    localparam int idxW = $clog2(`MEM_DEPTH);

    memPkg::byte_t mem [0:`MEM_DEPTH-1];
    logic [idxW-1:0] idx;

    assign idx = addr[idxW-1:0];

    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old byte when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wbyte;
        end
        rbyte <= mem[idx];
    end

endmodule

//--- loadAssembler.sv
`timescale 1ns/1ps

module loadAssembler (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           capture,
    input  logic           clearWord,
    input  memPkg::stage_t stage,
    input  memPkg::len_t   len,
    input  memPkg::byte_t  ramByte,
    output memPkg::word_t  word
);

    localparam int lanes = $bits(memPkg::word_t) / 8;

    memPkg::word_t hold;
    logic [1:0]    laneSel;
    logic          byteValid;

    // byte on ramByte was addressed one stage earlier
    assign laneSel   = 2'(stage - memPkg::stage_t'(1));
    assign byteValid = (stage != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            hold <= '0;
        end else if (rdy) begin
            if (clearWord) begin
                hold <= '0;
            end else if (capture && byteValid) begin
                hold[laneSel*8 +: 8] <= ramByte;
            end
        end
    end

    // final byte merged so the result is ready in the done cycle
    always_comb begin
        word = hold;
        if (byteValid) begin
            word[laneSel*8 +: 8] = ramByte;
        end
        for (int i = 0; i < lanes; i++) begin
            if (memPkg::len_t'(i) >= len) begin
                word[i*8 +: 8] = '0;
            end
        end
    end

endmodule

//--- memCtrl_settings.svh
`ifndef MEM_CTRL_SETTINGS_SVH
`define MEM_CTRL_SETTINGS_SVH

// byte address width seen by both requesters
`define MEM_ADDR_W 17

// RAM size in bytes, only the low address bits reach the array
`define MEM_DEPTH 4096

// bytes per instruction fetch
`define FETCH_BYTES 4

`endif

//--- memPkg.sv
`include "memCtrl_settings.svh"

package memPkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [7:0]             byte_t;
    typedef logic [31:0]            word_t;

    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] len_t;

    // byte stage of the running access
    typedef logic [2:0] stage_t;

    typedef enum logic [1:0] {
        ownNone  = 2'd0,
        ownFetch = 2'd1,
        ownData  = 2'd2
    } busOwner_e;

    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stFetch = 2'd1,
        stLoad  = 2'd2,
        stStore = 2'd3
    } arbState_e;

endpackage

//--- memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              fetchEn,
    input  memPkg::addr_t     fetchAddr,
    input  logic              dataEn,
    input  logic              dataStore,
    input  memPkg::len_t      dataLen,
    input  memPkg::addr_t     dataAddr,
    input  memPkg::word_t     dataWdata,
    output memPkg::busOwner_e owner,
    output logic              fetchDone,
    output memPkg::word_t     fetchInst,
    output logic              dataDone,
    output memPkg::word_t     dataRdata
);

    logic           cntStart;
    logic           cntStep;
    logic           ramWe;
    logic           capture;
    logic           clearWord;
    logic           isLast;
    logic           storeMode;
    memPkg::len_t   accLen;
    memPkg::stage_t stage;
    memPkg::stage_t addrStage;
    memPkg::addr_t  addrBase;
    memPkg::addr_t  ramAddr;
    memPkg::byte_t  wbyte;
    memPkg::byte_t  rbyte;
    memPkg::word_t  word;

    accessArbiter uArbiter (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .isLast    (isLast),
        .owner     (owner),
        .cntStart  (cntStart),
        .cntStep   (cntStep),
        .accLen    (accLen),
        .ramWe     (ramWe),
        .capture   (capture),
        .clearWord (clearWord),
        .fetchDone (fetchDone),
        .dataDone  (dataDone)
    );

    assign storeMode = (owner == memPkg::ownData) && dataStore;

    byteCounter uCounter (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .start     (cntStart),
        .step      (cntStep),
        .len       (accLen),
        .storeMode (storeMode),
        .stage     (stage),
        .isLast    (isLast)
    );

    assign addrBase = (owner == memPkg::ownFetch) ? fetchAddr : dataAddr;

    // while stalled re-read the byte already on rbyte so it is not lost
    assign addrStage = rdy ? stage : stage - memPkg::stage_t'(1);
    assign ramAddr   = addrBase + memPkg::addr_t'(addrStage);

    storeSerializer uSerializer (
        .wdata (dataWdata),
        .stage (stage),
        .wbyte (wbyte)
    );

    byteRam uRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wbyte (wbyte),
        .rbyte (rbyte)
    );

    loadAssembler uAssembler (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .capture   (capture),
        .clearWord (clearWord),
        .stage     (stage),
        .len       (accLen),
        .ramByte   (rbyte),
        .word      (word)
    );

    assign fetchInst = fetchDone ? word : '0;
    assign dataRdata = dataDone ? word : '0;

endmodule

//--- memSubsystem_tb_checks.svh
`ifndef MEM_SUBSYSTEM_TB_CHECKS_SVH
`define MEM_SUBSYSTEM_TB_CHECKS_SVH

    // reference copy of the RAM contents
    memPkg::byte_t memModel [0:`MEM_DEPTH-1];

    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            memModel[i] = '0;
        end
    end

    // only the low address bits select a RAM byte
    function automatic int modelIndex(memPkg::addr_t addr, int offset);
        memPkg::addr_t a;
        a = addr + memPkg::addr_t'(offset);
        return int'(a) % `MEM_DEPTH;
    endfunction

    task automatic modelStore(memPkg::addr_t addr, memPkg::len_t len, memPkg::word_t wdata);
        for (int i = 0; i < int'(len); i++) begin
            memModel[modelIndex(addr, i)] = wdata[i*8 +: 8];
        end
    endtask

    // little endian, lanes at or above len stay zero
    function automatic memPkg::word_t modelLoad(memPkg::addr_t addr, memPkg::len_t len);
        memPkg::word_t w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[i*8 +: 8] = memModel[modelIndex(addr, i)];
        end
        return w;
    endfunction

    task automatic checkWord(string what, memPkg::word_t expected, memPkg::word_t actual);
        assert (actual === expected) else begin
            errCount++;
            $display("ERR %s %s: expected %h, actual %h", curTest, what, expected, actual);
        end
    endtask

    task automatic checkCount(string what, int expected, int actual);
        assert (actual == expected) else begin
            errCount++;
            $display("ERR %s %s: expected %0d, actual %0d", curTest, what, expected, actual);
        end
    endtask

    function automatic int totalErrors();
        return errCount + ruleErrCount;
    endfunction

    task automatic beginTest(string name);
        curTest      = name;
        testErrStart = totalErrors();
    endtask

    // waits for the rule checks of the last cycle before reporting
    task automatic endTest();
        @(posedge clk);
        testCount++;
        if (totalErrors() != testErrStart) begin
            failCount++;
            $display("test %s failed with %0d errors", curTest, totalErrors() - testErrStart);
        end else begin
            $display("test %s passed", curTest);
        end
        @(negedge clk);
    endtask

`endif

//--- memSubsystem_tb.sv
`timescale 1ns/1ps
`include "memCtrl_settings.svh"

module memSubsystem_tb;

    localparam int resetCycles = 3;
    localparam int accessCount = 38;
    localparam int cycleLimit  = 20 * accessCount + resetCycles;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              fetchEn;
    memPkg::addr_t     fetchAddr;
    logic              dataEn;
    logic              dataStore;
    memPkg::len_t      dataLen;
    memPkg::addr_t     dataAddr;
    memPkg::word_t     dataWdata;
    memPkg::busOwner_e owner;
    logic              fetchDone;
    memPkg::word_t     fetchInst;
    logic              dataDone;
    memPkg::word_t     dataRdata;

    // DUT outputs captured at the rising edge
    logic              rstQ;
    logic              rdyQ;
    logic              ramWeQ;
    memPkg::busOwner_e ownerQ;
    logic              fetchDoneQ;
    logic              dataDoneQ;
    memPkg::word_t     fetchInstQ;
    memPkg::word_t     dataRdataQ;

    logic [31:0] lcgState = 32'hb679_0876;
    int          cycleCount = 0;
    int          errCount = 0;
    int          ruleErrCount = 0;
    int          testCount = 0;
    int          failCount = 0;
    int          testErrStart = 0;
    string       curTest = "none";

    memSubsystem DUT (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .owner     (owner),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

    `include "memSubsystem_tb_checks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        rstQ       <= rst;
        rdyQ       <= rdy;
        ramWeQ     <= DUT.ramWe;
        ownerQ     <= owner;
        fetchDoneQ <= fetchDone;
        dataDoneQ  <= dataDone;
        fetchInstQ <= fetchInst;
        dataRdataQ <= dataRdata;
    end

    // rules for every cycle, read from the captured values
    always @(negedge clk) begin
        if (!rstQ) begin
            assert (rdyQ || !(ramWeQ || dataDoneQ || fetchDoneQ)) else begin
                ruleErrCount++;
                $display("%s: RAM write or done pulse while rdy was low", curTest);
            end
            assert (!(dataDoneQ && fetchDoneQ)) else begin
                ruleErrCount++;
                $display("%s: both done pulses high in one cycle", curTest);
            end
            assert (!fetchDoneQ || ownerQ == memPkg::ownFetch) else begin
                ruleErrCount++;
                $display("%s: fetch done while fetch did not own the bus", curTest);
            end
            assert (!dataDoneQ || ownerQ == memPkg::ownData) else begin
                ruleErrCount++;
                $display("%s: data done while data did not own the bus", curTest);
            end
            assert ((fetchDoneQ || fetchInstQ == '0) && (dataDoneQ || dataRdataQ == '0)) else begin
                ruleErrCount++;
                $display("%s: result port not zero outside its done cycle", curTest);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles in test %s, a done pulse never came",
                     cycleCount, curTest);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState ^ (lcgState >> 15);
    endfunction

    function automatic memPkg::len_t pickLen(int sel);
        case (sel)
            0:       return 3'd1;
            1:       return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // edges counts from the grant edge, rdy is low at edges stallAt onward
    task automatic dataAccess(
        input  logic          store,
        input  memPkg::len_t  len,
        input  memPkg::addr_t addr,
        input  memPkg::word_t wdata,
        input  int            stallAt,
        input  int            stallLen,
        output memPkg::word_t rdata,
        output int            edges
    );
        int   n;
        logic doneSeen;
        dataEn    = 1'b1;
        dataStore = store;
        dataLen   = len;
        dataAddr  = addr;
        dataWdata = wdata;
        n         = 0;
        doneSeen  = 1'b0;
        while (!doneSeen) begin
            rdy = !((n >= stallAt) && (n < stallAt + stallLen));
            @(negedge clk);
            n++;
            doneSeen = dataDoneQ;
        end
        rdata  = dataRdataQ;
        edges  = n - 1;
        dataEn = 1'b0;
        rdy    = 1'b1;
        if (store) begin
            modelStore(addr, len, wdata);
        end
        @(negedge clk);
    endtask

    task automatic fetchAccess(input memPkg::addr_t addr, output memPkg::word_t inst,
                               output int edges);
        int n;
        fetchEn   = 1'b1;
        fetchAddr = addr;
        n         = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!fetchDoneQ);
        inst    = fetchInstQ;
        edges   = n - 1;
        fetchEn = 1'b0;
        @(negedge clk);
    endtask

    // load and fetch raised in the same cycle
    task automatic dualAccess(
        input  memPkg::len_t      len,
        input  memPkg::addr_t     addr,
        output memPkg::word_t     rdata,
        output memPkg::word_t     inst,
        output int                dataEdge,
        output int                fetchEdge,
        output memPkg::busOwner_e grantOwner
    );
        int n;
        dataEn     = 1'b1;
        dataStore  = 1'b0;
        dataLen    = len;
        dataAddr   = addr;
        fetchEn    = 1'b1;
        fetchAddr  = addr;
        n          = 0;
        grantOwner = memPkg::ownNone;
        while (dataEn || fetchEn) begin
            @(negedge clk);
            n++;
            if (n == 1) begin
                grantOwner = owner;
            end
            if (dataEn && dataDoneQ) begin
                rdata    = dataRdataQ;
                dataEdge = n - 1;
                dataEn   = 1'b0;
            end
            if (fetchEn && fetchDoneQ) begin
                inst      = fetchInstQ;
                fetchEdge = n - 1;
                fetchEn   = 1'b0;
            end
        end
        @(negedge clk);
    endtask

    initial begin
        memPkg::word_t     rdata;
        memPkg::word_t     inst;
        memPkg::word_t     wdata;
        memPkg::addr_t     addr;
        memPkg::len_t      len;
        memPkg::busOwner_e grantOwner;
        int                edges;
        int                fetchEdge;
        int                stallAt;
        int                stallLen;
        rst       = 1'b1;
        rdy       = 1'b1;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataStore = 1'b0;
        dataLen   = 3'd1;
        dataAddr  = '0;
        dataWdata = '0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        beginTest("reset");
        repeat (6) begin
            @(negedge clk);
            checkCount("owner after reset", int'(memPkg::ownNone), int'(owner));
            checkCount("done after reset", 0, int'(fetchDoneQ) + int'(dataDoneQ));
        end
        endTest();

        beginTest("roundTrip");
        for (int r = 0; r < 6; r++) begin
            len   = pickLen(r % 3);
            addr  = memPkg::addr_t'(nextRandom());
            wdata = nextRandom();
            dataAccess(1'b1, len, addr, wdata, 0, 0, rdata, edges);
            checkCount("store latency", int'(len), edges);
            dataAccess(1'b0, len, addr, '0, 0, 0, rdata, edges);
            checkCount("load latency", int'(len) + 1, edges);
            checkWord("load data", modelLoad(addr, len), rdata);
        end
        endTest();

        beginTest("fetch");
        for (int r = 0; r < 3; r++) begin
            addr = memPkg::addr_t'(nextRandom());
            dataAccess(1'b1, 3'd4, addr, nextRandom(), 0, 0, rdata, edges);
            // data address parked elsewhere, the fetch has to use its own
            dataAddr = ~addr;
            fetchAccess(addr, inst, edges);
            checkCount("fetch latency", `FETCH_BYTES + 1, edges);
            checkWord("instruction", modelLoad(addr, 3'(`FETCH_BYTES)), inst);
        end
        endTest();

        beginTest("priority");
        for (int r = 0; r < 2; r++) begin
            len  = pickLen(int'(nextRandom() % 3));
            addr = memPkg::addr_t'(nextRandom());
            dataAccess(1'b1, 3'd4, addr, nextRandom(), 0, 0, rdata, edges);
            dualAccess(len, addr, rdata, inst, edges, fetchEdge, grantOwner);
            checkCount("owner at grant", int'(memPkg::ownData), int'(grantOwner));
            checkCount("load latency", int'(len) + 1, edges);
            // fetch granted one edge after the load ends
            checkCount("fetch done edge", int'(len) + `FETCH_BYTES + 3, fetchEdge);
            checkWord("load data", modelLoad(addr, len), rdata);
            checkWord("instruction", modelLoad(addr, 3'(`FETCH_BYTES)), inst);
        end
        endTest();

        beginTest("stall");
        for (int r = 0; r < 4; r++) begin
            len      = pickLen(int'(nextRandom() % 3));
            addr     = memPkg::addr_t'(nextRandom());
            stallAt  = int'(nextRandom() % (int'(len) + 1));
            stallLen = 1 + int'(nextRandom() % 4);
            dataAccess(1'b1, len, addr, nextRandom(), stallAt, stallLen, rdata, edges);
            checkCount("stalled store latency", int'(len) + stallLen, edges);
            stallAt  = int'(nextRandom() % (int'(len) + 2));
            stallLen = 1 + int'(nextRandom() % 4);
            dataAccess(1'b0, len, addr, '0, stallAt, stallLen, rdata, edges);
            checkCount("stalled load latency", int'(len) + 1 + stallLen, edges);
            checkWord("stalled load data", modelLoad(addr, len), rdata);
        end
        endTest();

        beginTest("partialStore");
        for (int r = 0; r < 2; r++) begin
            addr  = memPkg::addr_t'(nextRandom());
            wdata = nextRandom();
            dataAccess(1'b1, 3'd4, addr, wdata, 0, 0, rdata, edges);
            dataAccess(1'b1, 3'd1, addr + memPkg::addr_t'(nextRandom() % 4), ~wdata, 0, 0,
                       rdata, edges);
            dataAccess(1'b0, 3'd4, addr, '0, 0, 0, rdata, edges);
            checkWord("merged word", modelLoad(addr, 3'd4), rdata);
        end
        endTest();

        @(posedge clk);
        $display("summary: %0d tests, %0d failed, %0d errors",
                 testCount, failCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
memPkg.sv
byteRam.sv
accessArbiter.sv
byteCounter.sv
loadAssembler.sv
storeSerializer.sv
memSubsystem.sv
memSubsystem_tb.sv

//--- storeSerializer.sv
`timescale 1ns/1ps

module storeSerializer (
    input  memPkg::word_t  wdata,
    input  memPkg::stage_t stage,
    output memPkg::byte_t  wbyte
);

    // little endian, stage 0 writes the low byte
    always_comb begin
        case (stage)
            3'd0:    wbyte = wdata[7:0];
            3'd1:    wbyte = wdata[15:8];
            3'd2:    wbyte = wdata[23:16];
            3'd3:    wbyte = wdata[31:24];
            default: wbyte = '0;
        endcase
    end

endmodule
